/* flist.f */
+incdir+include
rtl/softreg_pkg.sv
rtl/rst_sync.sv
rtl/sr_pipe.sv
rtl/sr_timeout.sv
rtl/sr_route_fsm.sv
rtl/app_regfile.sv
rtl/softreg_shell.sv
bench/sr_checker.sv
bench/tb_softreg_shell.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_softreg_shell
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_softreg_shell.sv */
// ------------------------------------------------
// Soft-register shell testbench
// Clock, reset, random requests and a watchdog
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "softreg_defines.svh"

module tb_softreg_shell
	import softreg_pkg::*;
();

	localparam int SEL_W      = `SR_APP_SEL_MSB - `SR_APP_SEL_LSB + 1;
	localparam int REG_W      = `SR_REG_SEL_MSB - `SR_REG_SEL_LSB + 1;
	localparam int RESP_BOUND = 2 * `SR_PIPE_STAGES + 4 + `SR_TIMEOUT_CYCLES;
	localparam int MAX_REQS   = 200;
	localparam int WDOG_CYC   = MAX_REQS * (RESP_BOUND + 4) + 500;
	localparam int DIS_SLOT   = 2;

	logic                    global_clk;
	logic                    rst_n;
	logic [`SR_NUM_APPS-1:0] app_enable;
	sr_req_t                 host_req;
	sr_resp_t                host_resp;
	logic                    busy;
	int                      errors;
	int                      checks;
	int                      accepted;
	int                      issued;
	int                      tb_errors;
	int                      err_mark;
	int                      tests_run;
	int                      slot;
	int                      rg;
	logic [31:0]             lcg_state;

	softreg_shell UUT (
		.global_clk (global_clk),
		.rst_n      (rst_n),
		.app_enable (app_enable),
		.host_req   (host_req),
		.host_resp  (host_resp),
		.busy       (busy)
	);

	sr_checker u_checker (
		.global_clk (global_clk),
		.rst_n      (rst_n),
		.app_enable (app_enable),
		.host_req   (host_req),
		.host_resp  (host_resp),
		.busy       (busy),
		.errors     (errors),
		.checks     (checks),
		.accepted   (accepted)
	);

	initial begin
		global_clk = 1'b0;
		forever #20 global_clk = ~global_clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Random filler outside the decoded fields
	function automatic logic [`SR_ADDR_W-1:0] reg_addr(int s, int r);
		logic [`SR_ADDR_W-1:0] a;
		a = lcg_next();
		a[`SR_APP_SEL_MSB:`SR_APP_SEL_LSB] = SEL_W'(s);
		a[`SR_REG_SEL_MSB:`SR_REG_SEL_LSB] = REG_W'(r);
		return a;
	endfunction

	task automatic wait_idle();
		int n;
		n = 0;
		@(posedge global_clk);
		while (busy && n < RESP_BOUND + 4) begin
			@(posedge global_clk);
			n++;
		end
		if (busy) begin
			$display("Busy stayed high for %0d cycles at %0d ns", n, $time);
			tb_errors++;
		end
	endtask

	// One-cycle request once the router is idle
	task automatic send_req(sr_op_t op, logic [`SR_ADDR_W-1:0] addr,
			logic [`SR_DATA_W-1:0] data);
		wait_idle();
		host_req <= '{valid: 1'b1, op: op, addr: addr, data: data};
		@(posedge global_clk);
		host_req <= '0;
		issued++;
	endtask

	task automatic write_reg(int s, int r);
		send_req(SR_WRITE, reg_addr(s, r), {lcg_next(), lcg_next()});
	endtask

	task automatic read_reg(int s, int r);
		send_req(SR_READ, reg_addr(s, r), {lcg_next(), lcg_next()});
	endtask

	task automatic finish_test(string name);
		wait_idle();
		repeat (2) @(posedge global_clk);
		tests_run++;
		$display("Test %0d (%s) finished at %0d ns with %0d errors", tests_run, name,
			$time, errors + tb_errors - err_mark);
		err_mark = errors + tb_errors;
	endtask

	initial begin
		lcg_state  = 32'h778b53dc;
		rst_n      = 1'b0;
		app_enable = '1;
		host_req   = '0;
		issued     = 0;
		tb_errors  = 0;
		err_mark   = 0;
		tests_run  = 0;
		repeat (10) @(posedge global_clk);
		rst_n <= 1'b1;
		repeat (4) @(posedge global_clk);
		if (busy || host_resp.valid) begin
			$display("CHECK FAILED at %0d ns: busy or response valid after reset", $time);
			tb_errors++;
		end

		for (int s = 0; s < `SR_NUM_APPS; s++)
			for (int r = 0; r <= `SR_WCOUNT_REG; r++) read_reg(s, r);
		finish_test("reset values");

		for (int i = 0; i < 40; i++) write_reg(lcg_next() % `SR_NUM_APPS, lcg_next() % 7);
		for (int s = 0; s < `SR_NUM_APPS; s++)
			for (int r = 0; r < `SR_WCOUNT_REG; r++) read_reg(s, r);
		finish_test("write then read");

		// Writes aimed at the counter still count
		for (int s = 0; s < `SR_NUM_APPS; s++)
			for (int i = 0; i <= s; i++) write_reg(s, `SR_WCOUNT_REG);
		for (int s = 0; s < `SR_NUM_APPS; s++) read_reg(s, `SR_WCOUNT_REG);
		finish_test("write counter");

		app_enable[DIS_SLOT] <= 1'b0;
		write_reg(DIS_SLOT, 1);
		write_reg(DIS_SLOT, `SR_WCOUNT_REG);
		read_reg(DIS_SLOT, 1);
		read_reg(DIS_SLOT, `SR_WCOUNT_REG);
		read_reg(1, `SR_WCOUNT_REG);
		wait_idle();
		app_enable[DIS_SLOT] <= 1'b1;
		for (int r = 0; r <= `SR_WCOUNT_REG; r++) read_reg(DIS_SLOT, r);
		finish_test("timeout on disabled slot");

		// Back-to-back writes and reads as soon as busy drops
		for (int i = 0; i < 8; i++) begin
			slot = lcg_next() % `SR_NUM_APPS;
			rg   = lcg_next() % 7;
			write_reg(slot, rg);
			write_reg(slot, (rg + 1) % 7);
			read_reg(slot, rg);
			read_reg(slot, (rg + 1) % 7);
		end
		finish_test("busy discipline");
		if (issued != accepted) begin
			$display("%0d requests were issued but only %0d accepted", issued, accepted);
			tb_errors++;
		end

		$display("Tests %0d, reads checked %0d, errors %0d", tests_run, checks,
			errors + tb_errors);
		if (errors + tb_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		repeat (WDOG_CYC) @(posedge global_clk);
		$display("Watchdog expired after %0d cycles, the run hung", WDOG_CYC);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/sr_checker.sv */
// ------------------------------------------------
// Soft-register checker
// Shadow model of the slots and read data compare
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "softreg_defines.svh"

module sr_checker
	import softreg_pkg::*;
(
	input  wire logic                    global_clk,
	input  wire logic                    rst_n,
	input  wire logic [`SR_NUM_APPS-1:0] app_enable,
	input  wire sr_req_t                 host_req,
	input  wire sr_resp_t                host_resp,
	input  wire logic                    busy,
	output int                           errors,
	output int                           checks,
	output int                           accepted
);

	localparam int SEL_W      = `SR_APP_SEL_MSB - `SR_APP_SEL_LSB + 1;
	localparam int REG_W      = `SR_REG_SEL_MSB - `SR_REG_SEL_LSB + 1;
	localparam int RESP_BOUND = 2 * `SR_PIPE_STAGES + 4 + `SR_TIMEOUT_CYCLES;

	logic [`SR_DATA_W-1:0] shadow [`SR_NUM_APPS][`SR_WCOUNT_REG];
	logic [`SR_DATA_W-1:0] wr_count [`SR_NUM_APPS];
	// Expected read data in issue order
	logic [`SR_DATA_W-1:0] exp_data [16];
	logic [3:0]            exp_wr;
	logic [3:0]            exp_rd;
	logic                  taken_q;
	int                    pend_cycles;

	// Expected value of a read from the slot rules
	function automatic logic [`SR_DATA_W-1:0] expected_read(logic [SEL_W-1:0] slot,
			logic [REG_W-1:0] rg, logic en);
		if (!en) return `SR_TIMEOUT_DATA;
		else if (rg == `SR_WCOUNT_REG) return wr_count[slot];
		else return shadow[slot][rg];
	endfunction

	//--------------------------------------------------
	// Shadow model updated on every accepted request
	//--------------------------------------------------
	always @(posedge global_clk or negedge rst_n) begin
		logic [SEL_W-1:0] slot;
		logic [REG_W-1:0] rg;
		if (!rst_n) begin
			for (int s = 0; s < `SR_NUM_APPS; s++) begin
				for (int r = 0; r < `SR_WCOUNT_REG; r++) begin
					// Slot number sits in the top byte
					shadow[s][r] = `SR_DATA_W'(s) << (`SR_DATA_W - 8);
				end
				wr_count[s] = '0;
			end
			exp_wr   <= '0;
			accepted <= 0;
			taken_q  <= 1'b0;
		end else begin
			// Busy rises on the edge that samples a request
			taken_q <= host_req.valid && !busy;
			if (taken_q) begin
				if (busy) begin
					accepted <= accepted + 1;
				end else begin
					$display("Request before %0d ns was not taken, busy stayed low", $time);
				end
			end
			if (host_req.valid && !busy) begin
				slot = host_req.addr[`SR_APP_SEL_MSB:`SR_APP_SEL_LSB];
				rg   = host_req.addr[`SR_REG_SEL_MSB:`SR_REG_SEL_LSB];
				if (host_req.op == SR_READ) begin
					exp_data[exp_wr] <= expected_read(slot, rg, app_enable[slot]);
					exp_wr           <= exp_wr + 1'b1;
				end else if (app_enable[slot]) begin
					wr_count[slot] = wr_count[slot] + 1'b1;
					if (rg != `SR_WCOUNT_REG) shadow[slot][rg] = host_req.data;
				end
			end
		end
	end

	//--------------------------------------------------
	// Response compare
	//--------------------------------------------------
	always @(posedge global_clk or negedge rst_n) begin
		int fails;
		fails = 0;
		if (!rst_n) begin
			exp_rd      <= '0;
			pend_cycles <= 0;
			errors      <= 0;
			checks      <= 0;
		end else begin
			if (host_resp.valid) begin
				pend_cycles <= 0;
				if (busy) begin
					$display("CHECK FAILED at %0d ns: busy high with response", $time);
					fails++;
				end
				if (exp_rd == exp_wr) begin
					$display("Response at %0d ns arrived with no read outstanding", $time);
					fails++;
				end else begin
					checks <= checks + 1;
					exp_rd <= exp_rd + 1'b1;
					if (host_resp.data !== exp_data[exp_rd]) begin
						$display("CHECK FAILED at %0d ns: read data %h, expected %h",
							$time, host_resp.data, exp_data[exp_rd]);
						fails++;
					end
				end
			end else if (exp_rd != exp_wr) begin
				pend_cycles <= pend_cycles + 1;
				if (pend_cycles >= RESP_BOUND) begin
					$display("Read got no response within %0d cycles (at %0d ns)",
						RESP_BOUND, $time);
					fails++;
					exp_rd      <= exp_rd + 1'b1;
					pend_cycles <= 0;
				end
			end
			errors <= errors + fails;
		end
	end

endmodule

`default_nettype wire

/* rtl/softreg_shell.sv */
// ------------------------------------------------
// Soft-register shell top
// Reset, router, timeout, slot pipes, register blocks
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "softreg_defines.svh"

module softreg_shell
	import softreg_pkg::*;
(
	input  wire logic                    global_clk,
	input  wire logic                    rst_n,
	input  wire logic [`SR_NUM_APPS-1:0] app_enable,
	input  wire sr_req_t                 host_req,
	output sr_resp_t                     host_resp,
	output logic                         busy
);

	logic     sync_rst_n;
	logic     start_timer;
	logic     clear_timer;
	logic     expired;
	sr_req_t  route_req [`SR_NUM_APPS];
	sr_resp_t route_resp [`SR_NUM_APPS];

	rst_sync u_rst_sync (
		.global_clk (global_clk),
		.rst_n      (rst_n),
		.sync_rst_n (sync_rst_n)
	);

	sr_route_fsm u_router (
		.global_clk  (global_clk),
		.rst_n       (sync_rst_n),
		.host_req    (host_req),
		.host_resp   (host_resp),
		.busy        (busy),
		.app_req     (route_req),
		.app_resp    (route_resp),
		.start_timer (start_timer),
		.clear_timer (clear_timer),
		.expired     (expired)
	);

	sr_timeout u_timeout (
		.global_clk (global_clk),
		.rst_n      (sync_rst_n),
		.start      (start_timer),
		.clear      (clear_timer),
		.expired    (expired)
	);

	//------------------------------------------------
	// Application slots
	//------------------------------------------------
	for (genvar g = 0; g < `SR_NUM_APPS; g++) begin : g_app
		sr_req_t  app_req;
		sr_resp_t app_resp;

		sr_pipe #(
			.WIDTH  ($bits(sr_req_t)),
			.STAGES (`SR_PIPE_STAGES)
		) u_req_pipe (
			.global_clk (global_clk),
			.rst_n      (sync_rst_n),
			.in_bus     (route_req[g]),
			.out_bus    (app_req)
		);

		app_regfile #(
			.APP_ID (g)
		) u_regfile (
			.global_clk (global_clk),
			.rst_n      (sync_rst_n),
			.enable     (app_enable[g]),
			.req        (app_req),
			.resp       (app_resp)
		);

		sr_pipe #(
			.WIDTH  ($bits(sr_resp_t)),
			.STAGES (`SR_PIPE_STAGES)
		) u_resp_pipe (
			.global_clk (global_clk),
			.rst_n      (sync_rst_n),
			.in_bus     (app_resp),
			.out_bus    (route_resp[g])
		);
	end

endmodule

`default_nettype wire

/* rtl/app_regfile.sv */
// ------------------------------------------------
// Application register block
// Seven read/write registers and a write counter
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "softreg_defines.svh"

module app_regfile
	import softreg_pkg::*;
#(
	parameter int APP_ID = 0
) (
	input  wire logic    global_clk,
	input  wire logic    rst_n,
	input  wire logic    enable,
	input  wire sr_req_t req,
	output sr_resp_t     resp
);

	localparam int REG_W  = `SR_REG_SEL_MSB - `SR_REG_SEL_LSB + 1;
	localparam int NUM_RW = `SR_WCOUNT_REG;

	// Slot number in the top byte
	localparam logic [`SR_DATA_W-1:0] RST_VAL = {8'(APP_ID), {(`SR_DATA_W-8){1'b0}}};

	logic [`SR_DATA_W-1:0] regs [NUM_RW];
	logic [`SR_DATA_W-1:0] wcount;
	logic [`SR_DATA_W-1:0] rd_data;
	logic [`SR_DATA_W-1:0] resp_data;
	logic                  resp_valid;
	logic [REG_W-1:0]      reg_idx;
	logic                  wr_en;
	logic                  rd_en;

	assign reg_idx = req.addr[`SR_REG_SEL_MSB:`SR_REG_SEL_LSB];

	// A disabled slot ignores everything
	assign wr_en = enable && req.valid && (req.op == SR_WRITE);
	assign rd_en = enable && req.valid && (req.op == SR_READ);

	always_ff @(posedge global_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_RW; i++) begin
				regs[i] <= RST_VAL;
			end
			wcount     <= '0;
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= rd_en;
			if (wr_en) begin
				// Writes to the counter only count
				wcount <= wcount + 1'b1;
				if (int'(reg_idx) < NUM_RW) begin
					regs[reg_idx] <= req.data;
				end
			end
		end
	end

	always_comb begin
		rd_data = wcount;
		if (int'(reg_idx) < NUM_RW) begin
			rd_data = regs[reg_idx];
		end
	end

	always_ff @(posedge global_clk) begin
		if (rd_en) begin
			resp_data <= rd_data;
		end
	end

	assign resp = '{valid: resp_valid, data: resp_data};

endmodule

`default_nettype wire

/* rtl/sr_route_fsm.sv */
// ------------------------------------------------
// Soft-register router
// Decodes the slot, issues, waits, returns read data
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "softreg_defines.svh"

module sr_route_fsm
	import softreg_pkg::*;
(
	input  wire logic     global_clk,
	input  wire logic     rst_n,
	input  wire sr_req_t  host_req,
	output sr_resp_t      host_resp,
	output logic          busy,
	output sr_req_t       app_req [`SR_NUM_APPS],
	input  wire sr_resp_t app_resp [`SR_NUM_APPS],
	output logic          start_timer,
	output logic          clear_timer,
	input  wire logic     expired
);

	localparam int SEL_W = `SR_APP_SEL_MSB - `SR_APP_SEL_LSB + 1;

	route_state_t          state;
	sr_req_t               req_q;
	logic [SEL_W-1:0]      sel;
	logic [`SR_DATA_W-1:0] rdata_q;
	logic                  resp_valid_q;
	logic                  resp_hit;

	// Target slot of the latched request
	assign sel = req_q.addr[`SR_APP_SEL_MSB:`SR_APP_SEL_LSB];

	// Only a response from the latched slot while waiting counts
	assign resp_hit = (state == ST_WAIT) && app_resp[sel].valid;

	//------------------------------------------------
	// State register
	//------------------------------------------------
	always_ff @(posedge global_clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= ST_IDLE;
			resp_valid_q <= 1'b0;
		end else begin
			resp_valid_q <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (host_req.valid) begin
						state <= ST_ISSUE;
					end
				end
				ST_ISSUE: begin
					// Writes are posted and get no answer
					if (req_q.op == SR_READ) begin
						state <= ST_WAIT;
					end else begin
						state <= ST_IDLE;
					end
				end
				ST_WAIT: begin
					if (resp_hit || expired) begin
						state <= ST_RESPOND;
					end
				end
				ST_RESPOND: begin
					resp_valid_q <= 1'b1;
					state        <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	//------------------------------------------------
	// Request and read data capture
	//------------------------------------------------
	always_ff @(posedge global_clk) begin
		if ((state == ST_IDLE) && host_req.valid) begin
			req_q <= host_req;
		end
		// App data wins over a same-cycle expiry
		if (resp_hit) begin
			rdata_q <= app_resp[sel].data;
		end else if ((state == ST_WAIT) && expired) begin
			rdata_q <= `SR_TIMEOUT_DATA;
		end
	end

	// Decoded slot sees the request for one cycle
	for (genvar g = 0; g < `SR_NUM_APPS; g++) begin : g_issue
		assign app_req[g] = ((state == ST_ISSUE) && (sel == SEL_W'(g))) ? req_q : '0;
	end

	assign busy        = (state != ST_IDLE);
	assign start_timer = (state == ST_ISSUE) && (req_q.op == SR_READ);
	assign clear_timer = resp_hit;

	assign host_resp = '{valid: resp_valid_q, data: rdata_q};

endmodule

`default_nettype wire

/* rtl/sr_timeout.sv */
// ------------------------------------------------
// Read timeout counter
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "softreg_defines.svh"

module sr_timeout
	import softreg_pkg::*;
(
	input  wire logic global_clk,
	input  wire logic rst_n,
	input  wire logic start,
	input  wire logic clear,
	output logic      expired
);

	sr_tmo_cnt_t count;
	logic        armed;

	// Expiry lands SR_TIMEOUT_CYCLES after the start pulse
	always_ff @(posedge global_clk or negedge rst_n) begin
		if (!rst_n) begin
			armed <= 1'b0;
			count <= '0;
		end else if (start) begin
			armed <= 1'b1;
			count <= sr_tmo_cnt_t'(`SR_TIMEOUT_CYCLES - 1);
		end else if (clear || expired) begin
			armed <= 1'b0;
		end else if (armed) begin
			count <= count - 1'b1;
		end
	end

	assign expired = armed && (count == '0);

endmodule

`default_nettype wire

/* rtl/sr_pipe.sv */
// ------------------------------------------------
// Register delay line for soft-register buses
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sr_pipe
	import softreg_pkg::*;
#(
	parameter int WIDTH  = $bits(sr_req_t),
	parameter int STAGES = 2
) (
	input  wire logic             global_clk,
	input  wire logic             rst_n,
	input  wire logic [WIDTH-1:0] in_bus,
	output logic      [WIDTH-1:0] out_bus
);

	// One entry per stage that may hold its own item
	logic [WIDTH-1:0] stage_q [STAGES];

	always_ff @(posedge global_clk or negedge rst_n) begin
		if (!rst_n) begin
			// Cleared stages carry valid low
			for (int i = 0; i < STAGES; i++) begin
				stage_q[i] <= '0;
			end
		end else begin
			stage_q[0] <= in_bus;
			for (int i = 1; i < STAGES; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	assign out_bus = stage_q[STAGES-1];

endmodule

`default_nettype wire

/* rtl/rst_sync.sv */
// ------------------------------------------------
// Reset synchronizer
// Async assert and release after two clocks
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rst_sync (
	input  wire logic global_clk,
	input  wire logic rst_n,
	output logic      sync_rst_n
);

	logic meta_q;

	always_ff @(posedge global_clk or negedge rst_n) begin
		if (!rst_n) begin
			meta_q     <= 1'b0;
			sync_rst_n <= 1'b0;
		end else begin
			meta_q     <= 1'b1;
			sync_rst_n <= meta_q;
		end
	end

endmodule

`default_nettype wire

/* rtl/softreg_pkg.sv */
// ------------------------------------------------
// Soft-register shell types
// Request and response buses, opcodes, router states
// ------------------------------------------------
`default_nettype none

`include "softreg_defines.svh"

package softreg_pkg;

	// Opcode carried by every request
	typedef enum logic {
		SR_READ  = 1'b0,
		SR_WRITE = 1'b1
	} sr_op_t;

	// Host or router request of 98 bits
	typedef struct packed {
		logic                  valid;
		sr_op_t                op;
		logic [`SR_ADDR_W-1:0] addr;
		logic [`SR_DATA_W-1:0] data;
	} sr_req_t;

	// Read response of 65 bits
	typedef struct packed {
		logic                  valid;
		logic [`SR_DATA_W-1:0] data;
	} sr_resp_t;

	// Router FSM
	typedef enum logic [1:0] {
		ST_IDLE    = 2'd0,
		ST_ISSUE   = 2'd1,
		ST_WAIT    = 2'd2,
		ST_RESPOND = 2'd3
	} route_state_t;

	// Down-counter of the read timeout
	typedef logic [$clog2(`SR_TIMEOUT_CYCLES)-1:0] sr_tmo_cnt_t;

endpackage

`default_nettype wire

/* include/softreg_defines.svh */
// ------------------------------------------------
// Soft-register shell parameters
// Slot count, address fields, pipe depth, timeout
// ------------------------------------------------
`ifndef SOFTREG_DEFINES_SVH
`define SOFTREG_DEFINES_SVH

// Application slots
`define SR_NUM_APPS 4

// Bus widths
`define SR_ADDR_W 32
`define SR_DATA_W 64

// Address decode of slot and register select
`define SR_APP_SEL_LSB 8
`define SR_APP_SEL_MSB 9
`define SR_REG_SEL_LSB 3
`define SR_REG_SEL_MSB 5

// Read-only write counter register
`define SR_WCOUNT_REG 7

// Stages per direction between router and slot
`define SR_PIPE_STAGES 2

// Read timeout and the data returned on expiry
`define SR_TIMEOUT_CYCLES 64
`define SR_TIMEOUT_DATA 64'hFFFF_DEAD_FFFF_DEAD

`endif
